// File: common/nocPkg.sv
package nocPkg;

    localparam int DATA_W  = 24;
    localparam int CHECK_W = 10;
    localparam int ID_W    = 5;
    localparam int NIBBLES = DATA_W / 4;

    // length field carried by every head flit
    localparam logic [ID_W-1:0] PAYLOAD_LEN = 5'd25;

    typedef enum logic [1:0] {
        FLIT_HEAD = 2'b00,
        FLIT_BODY = 2'b01,
        FLIT_TAIL = 2'b11
    } flitType_t;

    // =========================================================================
    // flit word layouts, all 32 bits with the type in the top two bits
    // =========================================================================
    typedef struct packed {
        flitType_t         fType;
        logic              req;
        logic [18:0]       rsvd;
        logic [ID_W-1:0]   srcId;
        logic [ID_W-1:0]   len;
    } headFlit_t;

    typedef struct packed {
        flitType_t         fType;
        logic [5:0]        pad;
        logic [DATA_W-1:0] data;
    } bodyFlit_t;

    typedef struct packed {
        flitType_t          fType;
        logic [19:0]        pad;
        logic [CHECK_W-1:0] check;
    } tailFlit_t;

    typedef union packed {
        headFlit_t head;
        bodyFlit_t body;
        tailFlit_t tail;
    } flit_t;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic              poison;
    } memReq_t;

    typedef struct packed {
        logic [ID_W-1:0]   srcId;
        logic [DATA_W-1:0] data;
        logic              checkErr;
    } pktResult_t;

    // low six bits hold the inverted parity per nibble, the top four the
    // inverted parity of each bit position taken across all nibbles
    function automatic logic [CHECK_W-1:0] calcCheck(input logic [DATA_W-1:0] data);
        logic [CHECK_W-1:0] chk;
        chk = '0;
        for (int n = 0; n < NIBBLES; n++) begin
            chk[n] = ~^data[4*n +: 4];
        end
        for (int b = 0; b < 4; b++) begin
            chk[NIBBLES+b] = 1'b1;
            for (int n = 0; n < NIBBLES; n++) begin
                chk[NIBBLES+b] ^= data[4*n+b];
            end
        end
        return chk;
    endfunction

endpackage

// File: memNi/memNi.sv
`timescale 1ns/10ps

module memNi #(
    parameter logic [nocPkg::ID_W-1:0] NODE_ID = '0
) (
    input  logic            clk,
    input  logic            rstn,

    input  logic            memValid_i,
    input  nocPkg::memReq_t memReq_i,
    output logic            memSent_o,

    input  logic            fifoFull_i,
    output logic            fifoWr_o,
    output nocPkg::flit_t   fifoWrData_o
);

    import nocPkg::*;

    typedef enum logic [1:0] {
        IDLE = 2'b00,
        HEAD = 2'b01,
        BODY = 2'b10,
        TAIL = 2'b11
    } state_t;

    state_t  state;
    state_t  stateD;
    memReq_t reqQ;
    flit_t   flitD;

    // =========================================================================
    // packet FSM, each flit state waits for room in the FIFO
    // =========================================================================
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state <= IDLE;
        end else begin
            state <= stateD;
        end
    end

    always_comb begin
        stateD = state;
        case (state)
            IDLE: if (memValid_i) stateD = HEAD;
            HEAD: if (!fifoFull_i) stateD = BODY;
            BODY: if (!fifoFull_i) stateD = TAIL;
            TAIL: if (!fifoFull_i) stateD = IDLE;
            default: stateD = IDLE;
        endcase
    end

    // the request is held until the tail has gone out
    always_ff @(posedge clk) begin
        if (memValid_i && state == IDLE) begin
            reqQ <= memReq_i;
        end
    end

    // =========================================================================
    // flit assembly
    // =========================================================================
    always_comb begin
        flitD = '0;
        case (state)
            HEAD: begin
                flitD.head.fType = FLIT_HEAD;
                flitD.head.req   = 1'b1;
                flitD.head.srcId = NODE_ID;
                flitD.head.len   = PAYLOAD_LEN;
            end
            BODY: begin
                flitD.body.fType = FLIT_BODY;
                flitD.body.data  = reqQ.data;
            end
            TAIL: begin
                // a poisoned word goes out with every check bit flipped
                flitD.tail.fType = FLIT_TAIL;
                flitD.tail.check = calcCheck(reqQ.data) ^ {CHECK_W{reqQ.poison}};
            end
            default: flitD = '0;
        endcase
    end

    assign fifoWrData_o = flitD;
    assign fifoWr_o     = (state != IDLE) && !fifoFull_i;
    assign memSent_o    = (state == TAIL) && !fifoFull_i;

    // the memory side may only strobe again after memSent_o
    property noStrobeWhileBusy;
        @(posedge clk) disable iff (!rstn) memValid_i |-> state == IDLE;
    endproperty
    aStrobeIdle: assert property (noStrobeWhileBusy);

endmodule

// File: src/flitFifo.sv
`timescale 1ns/10ps

module flitFifo #(
    parameter int DEPTH = 4
) (
    input  logic          clk,
    input  logic          rstn,

    input  logic          wr_i,
    input  nocPkg::flit_t wrData_i,
    output logic          full_o,

    input  logic          rd_i,
    output nocPkg::flit_t rdData_o,
    output logic          empty_o
);

    import nocPkg::*;

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    flit_t            mem [DEPTH];
    logic [PTR_W-1:0] wrPtr;
    logic [PTR_W-1:0] rdPtr;
    logic [CNT_W-1:0] count;
    logic             doWr;
    logic             doRd;

    function automatic logic [PTR_W-1:0] nextPtr(input logic [PTR_W-1:0] ptr);
        logic [PTR_W-1:0] nxt;
        if (ptr == PTR_W'(DEPTH - 1)) begin
            nxt = '0;
        end else begin
            nxt = ptr + 1'b1;
        end
        return nxt;
    endfunction

    assign doWr = wr_i && !full_o;
    assign doRd = rd_i && !empty_o;

    always_ff @(posedge clk) begin
        if (doWr) begin
            mem[wrPtr] <= wrData_i;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (doWr) begin
                wrPtr <= nextPtr(wrPtr);
            end
            if (doRd) begin
                rdPtr <= nextPtr(rdPtr);
            end
            case ({doWr, doRd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // first word fall-through, the head entry is always on the output
    assign rdData_o = mem[rdPtr];
    assign full_o   = (count == CNT_W'(DEPTH));
    assign empty_o  = (count == '0);

    aNoOverflow: assert property (@(posedge clk) disable iff (!rstn) wr_i |-> !full_o);
    aNoUnderflow: assert property (@(posedge clk) disable iff (!rstn) rd_i |-> !empty_o);

endmodule

// File: src/sinkNi.sv
`timescale 1ns/10ps

module sinkNi #(
    parameter logic [nocPkg::ID_W-1:0] NODE_ID = '0
) (
    input  logic               clk,
    input  logic               rstn,

    input  logic               fifoEmpty_i,
    input  nocPkg::flit_t      fifoRdData_i,
    output logic               fifoRd_o,

    input  logic               sinkStall_i,
    output logic               pktValid_o,
    output nocPkg::pktResult_t pktResult_o
);

    import nocPkg::*;

    typedef enum logic [1:0] {
        EXP_HEAD = 2'b00,
        EXP_BODY = 2'b01,
        EXP_TAIL = 2'b10
    } expect_t;

    expect_t           expQ;
    logic              errQ;
    logic [ID_W-1:0]   srcIdQ;
    logic [DATA_W-1:0] dataQ;
    flitType_t         inType;
    logic              headErr;
    logic              endPkt;
    logic              endErr;

    assign fifoRd_o = !fifoEmpty_i && !sinkStall_i;
    assign inType   = fifoRdData_i.head.fType;

    // the head must carry the fixed length and come from the paired node
    assign headErr = (fifoRdData_i.head.len != PAYLOAD_LEN) ||
                     (fifoRdData_i.head.srcId != NODE_ID);

    // =========================================================================
    // packet end detection and final check
    // =========================================================================
    always_comb begin
        endPkt = 1'b0;
        endErr = errQ;
        if (fifoRd_o && inType == FLIT_TAIL && expQ != EXP_HEAD) begin
            endPkt = 1'b1;
            // a tail straight after the head means the body went missing
            endErr = errQ || (expQ == EXP_BODY) ||
                     (fifoRdData_i.tail.check != calcCheck(dataQ));
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            expQ       <= EXP_HEAD;
            errQ       <= 1'b0;
            pktValid_o <= 1'b0;
        end else begin
            pktValid_o <= endPkt;
            if (fifoRd_o) begin
                case (inType)
                    // any head starts a fresh packet, this is how we resync
                    FLIT_HEAD: begin
                        expQ <= EXP_BODY;
                        errQ <= headErr;
                    end
                    FLIT_BODY: begin
                        if (expQ == EXP_BODY) begin
                            expQ <= EXP_TAIL;
                        end else if (expQ == EXP_TAIL) begin
                            errQ <= 1'b1;
                        end
                    end
                    FLIT_TAIL: expQ <= EXP_HEAD;
                    default: begin
                        if (expQ != EXP_HEAD) begin
                            errQ <= 1'b1;
                        end
                    end
                endcase
            end
        end
    end

    // stray body or tail flits outside a packet are dropped
    always_ff @(posedge clk) begin
        if (fifoRd_o && inType == FLIT_HEAD) begin
            srcIdQ <= fifoRdData_i.head.srcId;
        end
        if (fifoRd_o && inType == FLIT_BODY && expQ != EXP_HEAD) begin
            dataQ <= fifoRdData_i.body.data;
        end
        if (endPkt) begin
            pktResult_o <= '{srcId: srcIdQ, data: dataQ, checkErr: endErr};
        end
    end

endmodule

// File: src/nocLink.sv
`timescale 1ns/10ps

module nocLink #(
    parameter logic [nocPkg::ID_W-1:0] NODE_ID    = '0,
    parameter int                      FIFO_DEPTH = 4
) (
    input  logic               clk,
    input  logic               rstn,

    input  logic               memValid_i,
    input  nocPkg::memReq_t    memReq_i,
    output logic               memSent_o,

    input  logic               sinkStall_i,
    output logic               pktValid_o,
    output nocPkg::pktResult_t pktResult_o
);

    import nocPkg::*;

    logic  fifoFull;
    logic  fifoWr;
    flit_t fifoWrData;
    logic  fifoEmpty;
    logic  fifoRd;
    flit_t fifoRdData;

    // =========================================================================
    // memory side, link FIFO, receive side
    // =========================================================================
    memNi #(
        .NODE_ID      (NODE_ID)
    ) memNi0 (
        .clk          (clk),
        .rstn         (rstn),
        .memValid_i   (memValid_i),
        .memReq_i     (memReq_i),
        .memSent_o    (memSent_o),
        .fifoFull_i   (fifoFull),
        .fifoWr_o     (fifoWr),
        .fifoWrData_o (fifoWrData)
    );

    flitFifo #(
        .DEPTH        (FIFO_DEPTH)
    ) flitFifo0 (
        .clk          (clk),
        .rstn         (rstn),
        .wr_i         (fifoWr),
        .wrData_i     (fifoWrData),
        .full_o       (fifoFull),
        .rd_i         (fifoRd),
        .rdData_o     (fifoRdData),
        .empty_o      (fifoEmpty)
    );

    sinkNi #(
        .NODE_ID      (NODE_ID)
    ) sinkNi0 (
        .clk          (clk),
        .rstn         (rstn),
        .fifoEmpty_i  (fifoEmpty),
        .fifoRdData_i (fifoRdData),
        .fifoRd_o     (fifoRd),
        .sinkStall_i  (sinkStall_i),
        .pktValid_o   (pktValid_o),
        .pktResult_o  (pktResult_o)
    );

endmodule

// File: bench/tbChecker.sv
`timescale 1ns/10ps

module tbChecker #(
    parameter logic [nocPkg::ID_W-1:0] NODE_ID = '0
) (
    input  logic               clk,
    input  logic               rstn,
    input  logic               memValid_i,
    input  nocPkg::memReq_t    memReq_i,
    input  logic               memSent_i,
    input  logic               sinkStall_i,
    input  logic               pktValid_i,
    input  nocPkg::pktResult_t pktResult_i,
    input  logic [95:0]        testName_i,
    input  logic               checkLatency_i,
    output int                 errCount_o,
    output int                 pending_o,
    output int                 pktCount_o
);

    import nocPkg::*;

    localparam int NO_STALL_LATENCY = 5;

    memReq_t    reqQueue [$];
    int         strobeCycle [$];
    memReq_t    req;
    pktResult_t expected;
    int         cycle;
    int         latency;
    int         errs;
    int         checked;
    logic       busy;
    logic       stallQ;

    // the receiver must give back the paired node ID and the data untouched,
    // with checkErr set exactly for poisoned words
    function automatic pktResult_t expectResult(input memReq_t r);
        pktResult_t res;
        res.srcId    = NODE_ID;
        res.data     = r.data;
        res.checkErr = r.poison;
        return res;
    endfunction

    initial begin
        cycle   = 0;
        errs    = 0;
        checked = 0;
        busy    = 1'b0;
        stallQ  = 1'b0;
        pending_o = 0;
    end

    assign errCount_o = errs;
    assign pktCount_o = checked;

    // =========================================================================
    // compare process, sampled on every rising edge
    // =========================================================================
    always @(posedge clk) begin
        cycle++;
        if (!rstn) begin
            if (pktValid_i !== 1'b0 || memSent_i !== 1'b0) begin
                $display("%0s: pktValid_o or memSent_o was not low during reset", testName_i);
                errs++;
            end
            busy = 1'b0;
        end else begin
            if (memValid_i === 1'b1) begin
                reqQueue.push_back(memReq_i);
                strobeCycle.push_back(cycle);
            end
            if (memSent_i === 1'b1 && !busy) begin
                $display("%0s: memSent_o pulsed with no request in flight", testName_i);
                errs++;
            end
            busy = (busy && memSent_i !== 1'b1) || memValid_i === 1'b1;

            // pktValid_o now means the tail was read one edge ago
            if (pktValid_i === 1'b1) begin
                if (stallQ) begin
                    $display("%0s: a result came out while sinkStall_i was held", testName_i);
                    errs++;
                end
                if (reqQueue.size() == 0) begin
                    $display("%0s: a result came out with no request outstanding", testName_i);
                    errs++;
                end else begin
                    req      = reqQueue.pop_front();
                    latency  = cycle - strobeCycle.pop_front();
                    expected = expectResult(req);
                    checked++;
                    if (pktResult_i !== expected) begin
                        $display("error %0s: expected %0d/%06h/%0b, actual %0d/%06h/%0b",
                                 testName_i,
                                 expected.srcId, expected.data, expected.checkErr,
                                 pktResult_i.srcId, pktResult_i.data, pktResult_i.checkErr);
                        errs++;
                    end
                    if (checkLatency_i && latency != NO_STALL_LATENCY) begin
                        $display("error %0s: expected latency %0d, actual %0d", testName_i,
                                 NO_STALL_LATENCY, latency);
                        errs++;
                    end
                end
            end else if (pktValid_i !== 1'b0) begin
                $display("%0s: pktValid_o is unknown", testName_i);
                errs++;
            end
        end
        stallQ = sinkStall_i;
        pending_o <= reqQueue.size();
    end

endmodule

// File: bench/tbTop.sv
`timescale 1ns/10ps

module tbTop;

    import nocPkg::*;

    localparam logic [ID_W-1:0] NODE_ID = 5'd9;
    localparam int STREAM_PKTS = 40;
    localparam int STALL_PKTS  = 6;
    localparam int STALL_LEN   = 30;
    localparam int CYCLE_LIMIT = 20 * (1 + 4 + STREAM_PKTS + STALL_PKTS) + 200;

    logic        clk;
    logic        rstn;
    logic        memValid;
    memReq_t     memReq;
    logic        memSent;
    logic        sinkStall;
    logic        pktValid;
    pktResult_t  pktResult;
    logic [95:0] testName;
    logic        checkLatency;
    logic        streamDone;
    logic [15:0] lfsr;
    logic        stallBits [1024];
    int          stallIdx;
    int          errCount;
    int          pending;
    int          pktCount;
    int          cycles;
    int          errBefore;
    int          testsPassed;
    int          testsFailed;

    nocLink #(
        .NODE_ID     (NODE_ID),
        .FIFO_DEPTH  (4)
    ) dut0 (
        .clk         (clk),
        .rstn        (rstn),
        .memValid_i  (memValid),
        .memReq_i    (memReq),
        .memSent_o   (memSent),
        .sinkStall_i (sinkStall),
        .pktValid_o  (pktValid),
        .pktResult_o (pktResult)
    );

    tbChecker #(
        .NODE_ID        (NODE_ID)
    ) checker0 (
        .clk            (clk),
        .rstn           (rstn),
        .memValid_i     (memValid),
        .memReq_i       (memReq),
        .memSent_i      (memSent),
        .sinkStall_i    (sinkStall),
        .pktValid_i     (pktValid),
        .pktResult_i    (pktResult),
        .testName_i     (testName),
        .checkLatency_i (checkLatency),
        .errCount_o     (errCount),
        .pending_o      (pending),
        .pktCount_o     (pktCount)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout after %0d cycles with %0d packets still missing", cycles, pending);
            $display("Something failed");
            $finish;
        end
    end

    // 16-bit Fibonacci LFSR, taps 16 14 13 11
    function automatic logic lfsrBit();
        logic fb;
        fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
        lfsr = {lfsr[14:0], fb};
        return fb;
    endfunction

    function automatic logic [23:0] randBits(input int n);
        logic [23:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[22:0], lfsrBit()};
        end
        return v;
    endfunction

    // =========================================================================
    // stimulus tasks, each called on a rising edge and returning on one
    // =========================================================================
    task automatic sendPacket(input logic [23:0] data, input logic poison);
        memValid <= 1'b1;
        memReq   <= {data, poison};
        @(posedge clk);
        memValid <= 1'b0;
        while (memSent !== 1'b1) begin
            @(posedge clk);
        end
    endtask

    task automatic waitDrained();
        while (pending != 0) begin
            @(posedge clk);
        end
        repeat (2) @(posedge clk);
    endtask

    task automatic beginTest(input logic [95:0] name, input logic latency);
        @(posedge clk);
        testName     <= name;
        checkLatency <= latency;
        errBefore    = errCount;
    endtask

    // the error count is read between edges, once the checker has settled
    task automatic endTest();
        @(negedge clk);
        if (errCount == errBefore) begin
            testsPassed++;
            $display("test %0s: passed", testName);
        end else begin
            testsFailed++;
            $display("test %0s: failed with %0d errors", testName, errCount - errBefore);
        end
    endtask

    initial begin
        lfsr         = 16'd47967;
        rstn         = 1'b0;
        memValid     = 1'b0;
        memReq       = '0;
        sinkStall    = 1'b0;
        testName     = "reset";
        checkLatency = 1'b0;
        streamDone   = 1'b0;
        stallIdx     = 0;
        cycles       = 0;
        errBefore    = 0;
        testsPassed  = 0;
        testsFailed  = 0;
        repeat (3) @(posedge clk);
        rstn <= 1'b1;
        repeat (6) @(posedge clk);
        endTest();

        beginTest("single", 1'b1);
        sendPacket(randBits(24), 1'b0);
        waitDrained();
        endTest();

        beginTest("poison", 1'b0);
        for (int p = 0; p < 4; p++) begin
            sendPacket(randBits(24), (p % 2) == 0);
        end
        waitDrained();
        endTest();

        // stall pattern is drawn up front so only one process steps the LFSR
        beginTest("stream", 1'b0);
        for (int i = 0; i < 1024; i++) begin
            stallBits[i] = lfsrBit();
        end
        fork
            begin
                for (int p = 0; p < STREAM_PKTS; p++) begin
                    sendPacket(randBits(24), randBits(2) == 24'd3);
                end
                streamDone = 1'b1;
            end
            while (!streamDone) begin
                sinkStall <= stallBits[stallIdx % 1024];
                stallIdx++;
                @(posedge clk);
            end
        join
        sinkStall <= 1'b0;
        waitDrained();
        endTest();

        beginTest("long stall", 1'b0);
        sinkStall <= 1'b1;
        fork
            begin
                repeat (STALL_LEN) @(posedge clk);
                sinkStall <= 1'b0;
            end
            for (int p = 0; p < STALL_PKTS; p++) begin
                sendPacket(randBits(24), 1'b0);
            end
        join
        waitDrained();
        endTest();

        $display("%0d tests passed, %0d failed, %0d packets checked, %0d errors",
                 testsPassed, testsFailed, pktCount, errCount);
        if (testsFailed == 0 && errCount == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// File: filelist.f
common/nocPkg.sv
memNi/memNi.sv
src/flitFifo.sv
src/sinkNi.sv
src/nocLink.sv
bench/tbChecker.sv
bench/tbTop.sv
